// ==== sim.f ====
hw/icache_pkg.sv
hw/fetch_stage.sv
hw/icache_controller.sv
hw/icache_mem.sv
hw/icache_top.sv
dv/imem_model.sv
dv/icache_properties.sv
dv/icache_tb.sv

// ==== dv/icache_tb.sv ====
`default_nettype none

// drives random branches into the fetch path and follows the expected instruction stream
module icache_tb
	import icache_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int index_bits = 7;
	localparam int line_count = 1 << index_bits;
	localparam logic [31:0] lfsr_seed = 32'h10665e5a;

	logic clock = 1'b0;
	logic reset;
	logic branch_valid;
	addr_t branch_target;
	logic long_stalls;
	logic fetch_valid;
	addr_t fetch_pc;
	block_t fetch_inst;
	mem_command_t mem_command;
	addr_t mem_addr;
	mem_tag_t mem_response;
	block_t mem_data;
	mem_tag_t mem_data_tag;

	logic [31:0] lfsr_state = lfsr_seed;
	int value_errors = 0;
	int other_errors = 0;
	int delivered_count = 0;
	int region_loads = 0; // load cycles whose address lies in [region_low, region_high)
	addr_t region_low = '0;
	addr_t region_high = '0;
	addr_t exp_pc; // where the model expects the next delivery to come from
	logic after_reset;
	logic data_seen;
	logic predicted_hit;
	logic shadow_valid [line_count]; // lines known to hold the address in shadow_addr
	addr_t shadow_addr [line_count];

	always #2 clock = ~clock;

	icache_top #(
		.index_bits(index_bits)
	) u_dut (
		.clock(clock),
		.reset(reset),
		.branch_valid(branch_valid),
		.branch_target(branch_target),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_response(mem_response),
		.mem_data(mem_data),
		.mem_data_tag(mem_data_tag)
	);

	imem_model #(
		.seed(lfsr_seed)
	) u_memory (
		.clock(clock),
		.reset(reset),
		.long_stalls(long_stalls),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_response(mem_response),
		.mem_data(mem_data),
		.mem_data_tag(mem_data_tag)
	);

	function automatic logic [31:0] galois_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		int i;
		bits = '0;
		for (i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
		return bits;
	endfunction

	function automatic int line_of(input addr_t addr);
		return int'(addr[block_offset_bits +: index_bits]);
	endfunction

	// every block in memory holds its own address next to the inverted address
	function automatic block_t expected_block(input addr_t addr);
		return {~addr[31:0], addr[31:0]};
	endfunction

	task automatic check_addr(input addr_t actual, input addr_t expected, input string name);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic check_block(input block_t actual, input block_t expected, input string name);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic check_command(input mem_command_t actual, input mem_command_t expected,
			input string name);
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	// the reference model looks at the cycle that ends at this edge
	always @(posedge clock)
	begin
		if (reset)
		begin
			exp_pc = '0;
			after_reset = 1'b1;
			data_seen = 1'b0;
			foreach (shadow_valid[k])
				shadow_valid[k] = 1'b0;
		end
		else
		begin
			if (after_reset)
				check_command(mem_command, bus_none, "mem_command"); // no request in the first cycle
			after_reset = 1'b0;
			if (fetch_valid && !data_seen)
			begin
				other_errors++;
				$display("instruction delivered at %0t before any memory data came back", $time);
			end
			data_seen = data_seen || (mem_data_tag != '0);
			predicted_hit = shadow_valid[line_of(exp_pc)] && (shadow_addr[line_of(exp_pc)] == exp_pc);
			if (predicted_hit)
				check_command(mem_command, bus_none, "mem_command"); // a present line needs no load
			if (mem_command == bus_load)
			begin
				check_addr(mem_addr, exp_pc, "mem_addr");
				if (mem_addr >= region_low && mem_addr < region_high)
					region_loads++;
				if (mem_response != '0)
					shadow_valid[line_of(mem_addr)] = 1'b0; // this load may replace the line
			end
			if (branch_valid)
			begin
				if (fetch_valid)
				begin
					other_errors++;
					$display("instruction delivered in a branch cycle at %0t", $time);
				end
				exp_pc = branch_target;
			end
			else if (fetch_valid)
			begin
				check_addr(fetch_pc, exp_pc, "fetch_pc");
				check_block(fetch_inst, expected_block(exp_pc), "fetch_inst");
				shadow_valid[line_of(exp_pc)] = 1'b1;
				shadow_addr[line_of(exp_pc)] = exp_pc;
				delivered_count++;
				exp_pc = exp_pc + 64'd8;
			end
			else if (predicted_hit)
			begin
				other_errors++;
				$display("no delivery at %0t although the line for %h is present", $time, exp_pc);
			end
		end
	end

	// called at a falling edge, returns at a falling edge
	task automatic wait_deliveries(input int count, input int limit);
		int start;
		int cycles;
		start = delivered_count;
		cycles = 0;
		while (delivered_count < start + count && cycles < limit)
		begin
			@(negedge clock);
			cycles++;
		end
		if (delivered_count < start + count)
		begin
			other_errors++;
			$display("timeout after %0d cycles waiting for %0d deliveries", limit, count);
			finish_run();
		end
	endtask

	task automatic branch_to(input addr_t target);
		@(posedge clock);
		branch_valid <= 1'b1;
		branch_target <= target;
		@(posedge clock);
		branch_valid <= 1'b0;
		@(negedge clock);
	endtask

	// rare branches to block aligned targets below 4 KiB
	task automatic run_random(input int cycles);
		int i;
		int start;
		start = delivered_count;
		for (i = 0; i < cycles; i++)
		begin
			@(posedge clock);
			if (take_bits(5) == 0)
			begin
				branch_valid <= 1'b1;
				branch_target <= addr_t'(take_bits(9)) << block_offset_bits;
			end
			else
				branch_valid <= 1'b0;
		end
		@(posedge clock);
		branch_valid <= 1'b0;
		@(negedge clock);
		if (delivered_count == start)
		begin
			other_errors++;
			$display("no instruction delivered during %0d random cycles", cycles);
		end
	endtask

	// the second walk over the same blocks must find every line present
	task automatic loop_region(input addr_t base, input int blocks);
		int pass;
		for (pass = 0; pass < 2; pass++)
		begin
			region_low = base;
			region_high = base + addr_t'(blocks * 8);
			region_loads = 0;
			branch_to(base);
			wait_deliveries(blocks, blocks * 100);
			if (pass == 1 && region_loads != 0)
			begin
				other_errors++;
				$display("second pass from %h issued %0d load cycles", base, region_loads);
			end
		end
	endtask

	// two blocks share one line so each visit evicts the other
	task automatic conflict_pair(input addr_t first, input int rounds);
		addr_t second;
		addr_t target;
		int i;
		second = first + (addr_t'(1) << (index_bits + block_offset_bits));
		for (i = 0; i < 2 * rounds; i++)
		begin
			target = (i % 2 == 0) ? first : second;
			region_low = target;
			region_high = target + 64'd8;
			region_loads = 0;
			branch_to(target);
			wait_deliveries(1, 200);
			if (region_loads == 0)
			begin
				other_errors++;
				$display("%h delivered without a fresh load", target);
			end
		end
	endtask

	task automatic finish_run();
		int assertion_errors;
		assertion_errors = u_dut.u_controller.u_properties.assertion_errors;
		$display("errors: %0d value, %0d other, %0d assertion", value_errors, other_errors,
			assertion_errors);
		if (value_errors + other_errors + assertion_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	initial
	begin
		reset = 1'b1;
		branch_valid = 1'b0;
		branch_target = '0;
		long_stalls = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		wait_deliveries(48, 3000); // straight line code from address zero
		run_random(1500);
		loop_region(addr_t'('h2000), 32);
		conflict_pair(addr_t'('h1040), 3); // line 8 still holds 0x2040 from the loop
		@(posedge clock);
		long_stalls <= 1'b1;
		run_random(1500);
		wait_deliveries(1, 500);
		finish_run();
	end

endmodule

`default_nettype wire

// ==== dv/icache_properties.sv ====
`default_nettype none

// memory bus and line fill checks from inside the controller
module icache_properties
	import icache_pkg::*;
(
	input wire logic clock,
	input wire logic reset,
	input wire addr_t fetch_addr,
	input wire mem_command_t mem_command,
	input wire addr_t mem_addr,
	input wire mem_tag_t mem_response,
	input wire mem_tag_t mem_data_tag,
	input wire logic fill_enable
);
	timeunit 1ns;
	timeprecision 100ps;

	int assertion_errors = 0; // number of failed assertions so far
	mem_tag_t accepted_tag; // tag of the latest load the memory took that has not filled yet

	always_ff @(posedge clock)
	begin
		if (reset)
			accepted_tag <= '0;
		else if (mem_response != '0)
			accepted_tag <= mem_response;
		else if (fill_enable)
			accepted_tag <= '0; // every accepted load fills at most one line
	end

	// a waiting load stays put unless the fetch stage moved to another address
	load_held: assert property (@(posedge clock) disable iff (reset)
		(mem_command == bus_load && mem_response == '0)
			|=> (mem_command == bus_load && $stable(mem_addr)) || !$stable(fetch_addr))
	else
	begin
		assertion_errors++;
		$error("load request dropped or moved before the memory accepted it");
	end

	load_aligned: assert property (@(posedge clock) disable iff (reset)
		mem_command == bus_load |-> mem_addr[block_offset_bits-1:0] == '0)
	else
	begin
		assertion_errors++;
		$error("load address is not block aligned");
	end

	// a line is only filled with the data of the load the memory accepted last
	fill_tagged: assert property (@(posedge clock) disable iff (reset)
		fill_enable |-> (accepted_tag != '0) && (mem_data_tag == accepted_tag))
	else
	begin
		assertion_errors++;
		$error("line filled with data that belongs to no accepted load");
	end

	idle_after_reset: assert property (@(posedge clock) reset |=> mem_command == bus_none)
	else
	begin
		assertion_errors++;
		$error("memory request active right after reset");
	end

endmodule

bind icache_controller icache_properties u_properties (
	.clock(clock),
	.reset(reset),
	.fetch_addr(fetch_addr),
	.mem_command(mem_command),
	.mem_addr(mem_addr),
	.mem_response(mem_response),
	.mem_data_tag(mem_data_tag),
	.fill_enable(fill_enable)
);

`default_nettype wire

// ==== dv/imem_model.sv ====
`default_nettype none

// external memory with tagged split loads, the answer and the data come back at random times
module imem_model
	import icache_pkg::*;
#(
	parameter logic [31:0] seed = 32'h10665e5a
)
(
	input wire logic clock,
	input wire logic reset,
	input wire logic long_stalls, // accept loads rarely so the zero responses stretch out
	input wire mem_command_t mem_command,
	input wire addr_t mem_addr,
	output mem_tag_t mem_response,
	output block_t mem_data,
	output mem_tag_t mem_data_tag
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] lfsr_state = seed;
	logic accept_now = 1'b0; // decided one cycle ahead so the answer can follow the command at once
	mem_tag_t next_tag = 4'd1; // tags run 1 to 15 and skip zero
	block_t data_q = '0;
	mem_tag_t data_tag_q = '0;
	longint cycle = 0; // edges seen since reset

	// loads that were accepted and still owe their data
	mem_tag_t pend_tag [$];
	addr_t pend_addr [$];
	longint pend_due [$];
	int slot;
	int k;

	function automatic logic [31:0] galois_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	// one step of the register for every bit handed out
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		int i;
		bits = '0;
		for (i = 0; i < count; i++)
		begin
			bits = {bits[30:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
		return bits;
	endfunction

	// a nonzero answer only ever appears together with a load request
	assign mem_response = (mem_command == bus_load && accept_now) ? next_tag : '0;
	assign mem_data = data_q;
	assign mem_data_tag = data_tag_q;

	always @(posedge clock)
	begin
		if (reset)
		begin
			accept_now <= 1'b0;
			next_tag <= 4'd1;
			data_q <= '0;
			data_tag_q <= '0;
			cycle = 0;
			pend_tag.delete();
			pend_addr.delete();
			pend_due.delete();
		end
		else
		begin
			cycle++;
			if (mem_response != '0)
			begin
				pend_tag.push_back(mem_response);
				pend_addr.push_back(mem_addr);
				pend_due.push_back(cycle + longint'(take_bits(3)) + 1); // 1 to 8 cycles away
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			slot = -1;
			for (k = 0; k < pend_tag.size(); k++)
				if (slot < 0 && pend_due[k] <= cycle + 1)
					slot = k; // the oldest due entry goes first, later ones wait a cycle
			if (slot >= 0)
			begin
				data_tag_q <= pend_tag[slot];
				data_q <= {~pend_addr[slot][31:0], pend_addr[slot][31:0]};
				pend_tag.delete(slot);
				pend_addr.delete(slot);
				pend_due.delete(slot);
			end
			else
			begin
				data_tag_q <= '0;
				data_q <= '0;
			end
			accept_now <= long_stalls ? (take_bits(3) == 0) : (take_bits(2) != 0);
		end
	end

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
`default_nettype none

// instruction fetch path with the fetch stage, the cache controller and the cache array
module icache_top
	import icache_pkg::*;
#(
	parameter int index_bits = 7 // log2 of the number of cache lines
)
(
	input wire logic clock,
	input wire logic reset,

	// redirect into the fetch stage
	input wire logic branch_valid,
	input wire addr_t branch_target,

	// fetched instruction stream
	output logic fetch_valid,
	output addr_t fetch_pc,
	output block_t fetch_inst,

	// external memory bus
	output mem_command_t mem_command,
	output addr_t mem_addr,
	input wire mem_tag_t mem_response,
	input wire block_t mem_data,
	input wire mem_tag_t mem_data_tag
);

	localparam int tag_bits = tag_bits_for(index_bits); // width of the stored line tags

	// fetch stage and controller
	addr_t fetch_addr;
	logic cache_valid;
	block_t cache_data;

	// controller and array
	logic [index_bits-1:0] read_index;
	logic line_valid;
	logic [tag_bits-1:0] line_tag;
	block_t line_data;
	logic fill_enable;
	logic [index_bits-1:0] fill_index;
	logic [tag_bits-1:0] fill_tag;
	block_t fill_data;

	fetch_stage u_fetch_stage (
		.clock(clock),
		.reset(reset),
		.branch_valid(branch_valid),
		.branch_target(branch_target),
		.cache_valid(cache_valid),
		.cache_data(cache_data),
		.fetch_addr(fetch_addr),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst)
	);

	icache_controller #(
		.index_bits(index_bits)
	) u_controller (
		.clock(clock),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.cache_valid(cache_valid),
		.cache_data(cache_data),
		.read_index(read_index),
		.line_valid(line_valid),
		.line_tag(line_tag),
		.line_data(line_data),
		.fill_enable(fill_enable),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.fill_data(fill_data),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_response(mem_response),
		.mem_data(mem_data),
		.mem_data_tag(mem_data_tag)
	);

	icache_mem #(
		.index_bits(index_bits)
	) u_mem (
		.clock(clock),
		.reset(reset),
		.read_index(read_index),
		.line_valid(line_valid),
		.line_tag(line_tag),
		.line_data(line_data),
		.fill_enable(fill_enable),
		.fill_index(fill_index),
		.fill_tag(fill_tag),
		.fill_data(fill_data)
	);

endmodule

`default_nettype wire

// ==== hw/icache_mem.sv ====
`default_nettype none

// direct mapped storage with one block per line
module icache_mem
	import icache_pkg::*;
#(
	parameter int index_bits = 7,
	localparam int tag_bits = tag_bits_for(index_bits)
)
(
	input wire logic clock,
	input wire logic reset,

	// combinational read port
	input wire logic [index_bits-1:0] read_index,
	output logic line_valid,
	output logic [tag_bits-1:0] line_tag,
	output block_t line_data,

	// synchronous write port used by the line fill
	input wire logic fill_enable,
	input wire logic [index_bits-1:0] fill_index,
	input wire logic [tag_bits-1:0] fill_tag,
	input wire block_t fill_data
);

	localparam int line_count = 1 << index_bits; // 128 lines with the default index width

	logic [line_count-1:0] valid_bits; // one presence flag per line
	logic [tag_bits-1:0] tag_array [line_count];
	block_t data_array [line_count];

	// the controller compares the tag itself, the array just hands out the line
	assign line_valid = valid_bits[read_index];
	assign line_tag = tag_array[read_index];
	assign line_data = data_array[read_index];

	// valid bits are the only state that must be known after reset
	always_ff @(posedge clock)
	begin
		if (reset)
			valid_bits <= '0;
		else if (fill_enable)
			valid_bits[fill_index] <= 1'b1; // a line once filled stays valid until replaced
	end

	// a fill overwrites tag and data together, whatever the line held before
	always_ff @(posedge clock)
	begin
		if (fill_enable)
		begin
			tag_array[fill_index] <= fill_tag;
			data_array[fill_index] <= fill_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/icache_controller.sv ====
`default_nettype none

// decides hit or miss for the fetch address and runs one miss at a time on the memory bus
module icache_controller
	import icache_pkg::*;
#(
	parameter int index_bits = 7,
	localparam int tag_bits = tag_bits_for(index_bits)
)
(
	input wire logic clock,
	input wire logic reset,

	// fetch stage side
	input wire addr_t fetch_addr,
	output logic cache_valid,
	output block_t cache_data,

	// read port of the array
	output logic [index_bits-1:0] read_index,
	input wire logic line_valid,
	input wire logic [tag_bits-1:0] line_tag,
	input wire block_t line_data,

	// write port of the array
	output logic fill_enable,
	output logic [index_bits-1:0] fill_index,
	output logic [tag_bits-1:0] fill_tag,
	output block_t fill_data,

	// tagged split transaction memory
	output mem_command_t mem_command,
	output addr_t mem_addr,
	input wire mem_tag_t mem_response,
	input wire block_t mem_data,
	input wire mem_tag_t mem_data_tag
);

	logic [index_bits-1:0] current_index; // line selected by the fetch address
	logic [tag_bits-1:0] current_tag;
	logic [index_bits-1:0] last_index; // fetch address of the previous cycle
	logic [tag_bits-1:0] last_tag;
	mem_tag_t awaited_tag; // transaction id of the load whose data we still want
	logic miss_outstanding; // a miss exists that the memory has not accepted yet
	logic changed_addr;
	logic hit;
	logic data_match;
	logic update_awaited;
	logic unanswered_miss;

	// bits 31 down to 3 form the tag and the index, everything above is not looked at
	assign {current_tag, current_index} = fetch_addr[cached_addr_bits-1:block_offset_bits];
	assign read_index = current_index;

	// a new address appears after every delivery and after every branch
	assign changed_addr = (current_index != last_index) || (current_tag != last_tag);

	assign hit = line_valid && (line_tag == current_tag);
	assign cache_valid = hit; // the array answers in the same cycle
	assign cache_data = line_data;

	// the load always asks for the whole block holding fetch_addr
	assign mem_addr = block_align(fetch_addr);

	// the request starts one cycle after the miss is seen and stays up until accepted
	// it drops at once if the fetch stage has moved on to some other address
	assign mem_command = (miss_outstanding && !changed_addr) ? bus_load : bus_none;

	// zero never names a real transaction so an idle data tag cannot match it
	assign data_match = (mem_data_tag == awaited_tag) && (awaited_tag != '0);

	// the fill goes to the line of the current address, which is only the missed
	// address while that address has not changed
	assign fill_enable = data_match && !changed_addr;
	assign fill_index = current_index;
	assign fill_tag = current_tag;
	assign fill_data = mem_data; // the block is written exactly as the memory returns it

	// the awaited tag is reloaded while the request waits, when the data is consumed and
	// whenever the address moves, so a stale transaction is forgotten
	assign update_awaited = changed_addr || miss_outstanding || data_match;

	// on a new address a miss starts if the line is absent, otherwise the miss lasts
	// until the memory gives a nonzero response
	assign unanswered_miss = changed_addr ? !hit : (miss_outstanding && (mem_response == '0));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			last_index <= '1; // makes the first address after reset count as new
			last_tag <= '1;
			awaited_tag <= '0;
			miss_outstanding <= 1'b0;
		end
		else
		begin
			last_index <= current_index;
			last_tag <= current_tag;
			miss_outstanding <= unanswered_miss;
			if (update_awaited)
				awaited_tag <= mem_response; // zero except in the cycle of acceptance
		end
	end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`default_nettype none

// the fetch stage owns the program counter and hands out one block per hit
module fetch_stage
	import icache_pkg::*;
(
	input wire logic clock,
	input wire logic reset,

	// redirect from later in the pipeline
	input wire logic branch_valid,
	input wire addr_t branch_target,

	// answer from the cache controller for the current fetch_addr
	input wire logic cache_valid,
	input wire block_t cache_data,

	output addr_t fetch_addr, // address the cache is asked for this cycle

	// instruction stream toward decode
	output logic fetch_valid,
	output addr_t fetch_pc,
	output block_t fetch_inst
);

	// distance between two consecutive blocks
	localparam addr_t block_step = addr_t'(1) << block_offset_bits;

	addr_t pc; // address of the block being fetched right now
	addr_t next_pc; // what pc turns into at the coming edge
	logic deliver; // the block at pc goes out this cycle

	// the cache is always looking at the current pc, there is no separate request strobe
	assign fetch_addr = pc;

	// a branch in this cycle kills whatever the cache has for the old path
	assign deliver = cache_valid && !branch_valid;

	assign fetch_valid = deliver;
	assign fetch_pc = pc; // the pc and the data travel together with fetch_valid
	assign fetch_inst = cache_data;

	// branch wins over the sequential step
	always_comb
	begin
		next_pc = pc;
		if (branch_valid)
			next_pc = block_align(branch_target); // targets land on a block boundary
		else if (deliver)
			next_pc = pc + block_step; // move on only once the block was handed out
	end

	// the pc holds while a miss is pending since nothing gets delivered then
	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= '0; // execution starts at address zero
		else
			pc <= next_pc;
	end

endmodule

`default_nettype wire

// ==== hw/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// byte address as the fetch stage and the memory bus see it
	typedef logic [63:0] addr_t;

	// one cache block, which is also one fetched instruction word
	typedef logic [63:0] block_t;

	typedef logic [3:0] mem_tag_t; // zero stands for no transaction on either tag port

	// the memory bus knows only loads since the fetch path never writes
	typedef enum logic [1:0] {
		bus_none = 2'd0, // idle cycle, the memory ignores mem_addr
		bus_load = 2'd1  // read one block at mem_addr
	} mem_command_t;

	localparam int block_offset_bits = 3; // eight bytes per block so the pc steps by 8

	// only the low 32 address bits are split into tag, index and offset
	localparam int cached_addr_bits = 32;

	// the tag takes whatever of the low 32 bits the offset and index leave over
	function automatic int tag_bits_for(int index_bits);
		return cached_addr_bits - block_offset_bits - index_bits;
	endfunction

	// clears the offset bits so that an address points at the start of its block
	function automatic addr_t block_align(addr_t addr);
		return {addr[$bits(addr_t)-1:block_offset_bits], {block_offset_bits{1'b0}}};
	endfunction

endpackage

`default_nettype wire
